//--- logic/frame_sync_pkg.sv
package frame_sync_pkg;

    // frame structure
    localparam int SYM_PER_SF          = 14;
    localparam int SUBFRAMES_PER_FRAME = 20;
    localparam int SFN_COUNT           = 1024;
    localparam int SYMS_BTWN_SSB       = 280;

    // find window edges around the expected SSB
    localparam int FIND_EARLY_SAMPLES = 4;
    localparam int FIND_LATE_SAMPLES  = 3;

    // tag field widths
    localparam int SFN_W      = 10;
    localparam int SUBFRAME_W = 5;
    localparam int SYM_W      = 4;
    localparam int CP_LEN_W   = 9;
    localparam int TUSER_W    = SFN_W + SUBFRAME_W + SYM_W + CP_LEN_W;

    // symbols since the last SSB
    localparam int SSB_CNT_W = $clog2(SYMS_BTWN_SSB);

    typedef struct packed {
        logic [SFN_W-1:0]      sfn;
        logic [SUBFRAME_W-1:0] subframe;
        logic [SYM_W-1:0]      symbol;
        logic [CP_LEN_W-1:0]   cp_len;
    } frame_tag_t;

    typedef enum logic [1:0] {
        WAIT_FOR_SSB  = 2'd0,
        WAIT_FOR_IBAR = 2'd1,
        SYNCED        = 2'd2
    } sync_state_t;

    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } pss_mode_t;

endpackage

//--- logic/symbol_timing_if.sv
`timescale 1ns/1ps

interface symbol_timing_if import frame_sync_pkg::*; #(
    parameter int NFFT = 8
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP1_LEN = 20 * FFT_LEN / 256;
    localparam int CNT_W   = $clog2(FFT_LEN + CP1_LEN);

    // all of these describe the beat presented in the same cycle
    logic                 sample_valid;
    logic [CNT_W-1:0]     sample_cnt;
    frame_tag_t           tag;
    logic                 symbol_last;
    logic [SSB_CNT_W-1:0] syms_since_ssb;

    modport counter (
        output sample_valid, sample_cnt, tag, symbol_last, syms_since_ssb
    );

    modport observer (
        input sample_valid, sample_cnt, tag, symbol_last, syms_since_ssb
    );

endinterface

//--- logic/symbol_counter.sv
`timescale 1ns/1ps

module symbol_counter import frame_sync_pkg::*; #(
    parameter int NFFT = 8
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic             s_valid_i,
    input  logic             acquire_i,
    input  logic             realign_i,
    input  logic             counting_i,
    symbol_timing_if.counter tim
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP1_LEN = 20 * FFT_LEN / 256;
    localparam int CP2_LEN = 18 * FFT_LEN / 256;
    localparam int CNT_W   = $clog2(FFT_LEN + CP1_LEN);

    // first SSB symbol of the slot
    localparam int ACQ_SYMBOL = 2;

    logic [CNT_W-1:0]      sample_cnt_q;
    logic [SYM_W-1:0]      sym_q;
    logic [SYM_W-1:0]      sym_next;
    logic [SUBFRAME_W-1:0] subframe_q;
    logic [SFN_W-1:0]      sfn_q;
    logic [CP_LEN_W-1:0]   cp_len_q;
    logic [SSB_CNT_W-1:0]  syms_since_ssb_q;
    logic                  natural_last;
    logic                  symbol_end;
    logic                  advance;

    assign natural_last = sample_cnt_q == CNT_W'(FFT_LEN) + CNT_W'(cp_len_q) - 1'b1;
    // a realign closes the symbol on the current beat
    assign symbol_end   = natural_last || realign_i;
    assign advance      = counting_i && s_valid_i;
    assign sym_next     = (sym_q == SYM_W'(SYM_PER_SF - 1)) ? '0 : sym_q + 1'b1;

    assign tim.sample_valid   = s_valid_i;
    assign tim.sample_cnt     = sample_cnt_q;
    assign tim.tag            = '{sfn: sfn_q, subframe: subframe_q, symbol: sym_q,
                                  cp_len: cp_len_q};
    assign tim.symbol_last    = symbol_end;
    assign tim.syms_since_ssb = syms_since_ssb_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt_q     <= '0;
            sym_q            <= '0;
            subframe_q       <= '0;
            sfn_q            <= '0;
            cp_len_q         <= CP_LEN_W'(CP2_LEN);
            syms_since_ssb_q <= '0;
        end else if (acquire_i) begin
            // frame and subframe keep their values across a new acquisition
            sample_cnt_q     <= '0;
            sym_q            <= SYM_W'(ACQ_SYMBOL);
            cp_len_q         <= CP_LEN_W'(CP2_LEN);
            syms_since_ssb_q <= '0;
        end else if (advance) begin
            if (symbol_end) begin
                sample_cnt_q <= '0;
                sym_q        <= sym_next;

                // long CP at the start of each half subframe
                if (sym_next == SYM_W'(0) || sym_next == SYM_W'(7)) begin
                    cp_len_q <= CP_LEN_W'(CP1_LEN);
                end else begin
                    cp_len_q <= CP_LEN_W'(CP2_LEN);
                end

                // realign only comes with an accepted SSB
                if (realign_i || syms_since_ssb_q == SSB_CNT_W'(SYMS_BTWN_SSB - 1)) begin
                    syms_since_ssb_q <= '0;
                end else begin
                    syms_since_ssb_q <= syms_since_ssb_q + 1'b1;
                end

                if (sym_q == SYM_W'(SYM_PER_SF - 1)) begin
                    if (subframe_q == SUBFRAME_W'(SUBFRAMES_PER_FRAME - 1)) begin
                        subframe_q <= '0;
                        if (sfn_q == SFN_W'(SFN_COUNT - 1)) begin
                            sfn_q <= '0;
                        end else begin
                            sfn_q <= sfn_q + 1'b1;
                        end
                    end else begin
                        subframe_q <= subframe_q + 1'b1;
                    end
                end
            end else begin
                sample_cnt_q <= sample_cnt_q + 1'b1;
            end
        end
    end

endmodule

//--- logic/ssb_tracker.sv
`timescale 1ns/1ps

module ssb_tracker import frame_sync_pkg::*; #(
    parameter int NFFT = 8
) (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic               pss_valid_i,
    input  logic               ibar_valid_i,
    symbol_timing_if.observer  tim,
    output logic               acquire_o,
    output logic               realign_o,
    output logic               counting_o,
    output sync_state_t        state_o,
    output logic               ssb_start_o,
    output logic signed [7:0]  sample_cnt_mismatch_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP1_LEN = 20 * FFT_LEN / 256;
    localparam int CNT_W   = $clog2(FFT_LEN + CP1_LEN);

    sync_state_t              state_q;
    logic                     find_q;
    logic                     ssb_start_q;
    logic signed [7:0]        mismatch_q;
    logic [CNT_W-1:0]         sym_len;
    logic                     last_beat;
    logic                     open_window;
    logic                     hit;
    logic                     lost;
    logic signed [CNT_W:0]    early_offset;

    assign sym_len   = CNT_W'(FFT_LEN) + CNT_W'(tim.tag.cp_len);
    assign last_beat = tim.sample_cnt == sym_len - 1'b1;

    // window opens a few beats before the end of the last symbol of the SSB period
    assign open_window = state_q == SYNCED && !find_q && tim.sample_valid
                       && tim.syms_since_ssb == SSB_CNT_W'(SYMS_BTWN_SSB - 1)
                       && tim.sample_cnt == sym_len - CNT_W'(FIND_EARLY_SAMPLES);

    // sample 3 of the next symbol closes the window without a detection
    assign hit  = find_q && tim.sample_valid && pss_valid_i
                && tim.sample_cnt != CNT_W'(FIND_LATE_SAMPLES);
    assign lost = find_q && tim.sample_valid
                && tim.sample_cnt == CNT_W'(FIND_LATE_SAMPLES);

    // negative when the SSB shows up before the expected symbol end
    assign early_offset = signed'({1'b0, tim.sample_cnt}) - signed'({1'b0, sym_len});

    assign acquire_o  = state_q == WAIT_FOR_SSB && pss_valid_i;
    assign realign_o  = hit && !last_beat;
    assign counting_o = state_q != WAIT_FOR_SSB;

    assign state_o               = state_q;
    assign ssb_start_o           = ssb_start_q;
    assign sample_cnt_mismatch_o = mismatch_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= WAIT_FOR_SSB;
            find_q      <= 1'b0;
            ssb_start_q <= 1'b0;
            mismatch_q  <= '0;
        end else begin
            ssb_start_q <= hit;

            case (state_q)
                WAIT_FOR_SSB: begin
                    if (pss_valid_i) begin
                        state_q <= WAIT_FOR_IBAR;
                    end
                end
                WAIT_FOR_IBAR: begin
                    if (ibar_valid_i) begin
                        state_q <= SYNCED;
                    end
                end
                SYNCED: begin
                    if (lost) begin
                        state_q <= WAIT_FOR_SSB;
                    end
                end
                default: begin
                    state_q <= WAIT_FOR_SSB;
                end
            endcase

            if (hit || lost) begin
                find_q <= 1'b0;
            end else if (open_window) begin
                find_q <= 1'b1;
            end

            if (hit) begin
                if (last_beat) begin
                    mismatch_q <= '0;
                end else if (tim.sample_cnt < CNT_W'(FIND_LATE_SAMPLES)) begin
                    // late, already inside the next symbol
                    mismatch_q <= $signed(8'(tim.sample_cnt));
                end else begin
                    mismatch_q <= 8'(early_offset);
                end
            end
        end
    end

endmodule

//--- logic/pss_mode_ctrl.sv
`timescale 1ns/1ps

module pss_mode_ctrl import frame_sync_pkg::*; #(
    parameter int CLK_FREQ = 3840000
) (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  logic        pss_valid_i,
    output pss_mode_t   pss_mode_o,
    output logic [15:0] missed_ssbs_o
);

    // SSB period and the 0.1 ms guard around it
    localparam int CLKS_20MS  = CLK_FREQ / 50;
    localparam int CLKS_GUARD = CLK_FREQ / 10000;
    localparam int CNT_W      = $clog2(CLKS_20MS + CLKS_GUARD + 2);

    pss_mode_t        state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [15:0]      missed_q;
    logic             wake_up;
    logic             timed_out;

    assign wake_up   = clk_cnt_q > CNT_W'(CLKS_20MS - CLKS_GUARD);
    assign timed_out = clk_cnt_q > CNT_W'(CLKS_20MS + CLKS_GUARD);

    assign missed_ssbs_o = missed_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= MODE_SEARCH;
            pss_mode_o <= MODE_SEARCH;
            clk_cnt_q  <= '0;
            missed_q   <= '0;
        end else begin
            pss_mode_o <= state_q;

            case (state_q)
                MODE_SEARCH: begin
                    // any PSS restarts the period
                    if (pss_valid_i) begin
                        state_q   <= MODE_PAUSE;
                        clk_cnt_q <= CNT_W'(1);
                        missed_q  <= '0;
                    end
                end
                MODE_PAUSE: begin
                    clk_cnt_q <= clk_cnt_q + 1'b1;
                    if (wake_up) begin
                        state_q <= MODE_FIND;
                    end
                end
                MODE_FIND: begin
                    if (timed_out) begin
                        state_q  <= MODE_SEARCH;
                        missed_q <= missed_q + 1'b1;
                    end else if (pss_valid_i) begin
                        state_q   <= MODE_PAUSE;
                        clk_cnt_q <= CNT_W'(1);
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= MODE_SEARCH;
                end
            endcase
        end
    end

endmodule

//--- logic/sample_tagger.sv
`timescale 1ns/1ps

module sample_tagger import frame_sync_pkg::*; #(
    parameter int IN_DW = 32
) (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic [IN_DW-1:0]   s_data_i,
    input  logic               counting_i,
    symbol_timing_if.observer  tim,
    output logic [IN_DW-1:0]   m_data_o,
    output frame_tag_t         m_tuser_o,
    output logic               m_valid_o,
    output logic               m_last_o,
    output logic               symbol_start_o
);

    logic [IN_DW-1:0] data_q;
    frame_tag_t       tag_q;
    logic             valid_q;
    logic             last_q;
    logic             first_q;
    logic             beat;

    // only beats on the timing grid leave the block
    assign beat = counting_i && tim.sample_valid;

    // sample and tag travel together through both stages
    always_ff @(posedge clk_i) begin
        data_q    <= s_data_i;
        tag_q     <= tim.tag;
        m_data_o  <= data_q;
        m_tuser_o <= tag_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q        <= 1'b0;
            last_q         <= 1'b0;
            first_q        <= 1'b0;
            m_valid_o      <= 1'b0;
            m_last_o       <= 1'b0;
            symbol_start_o <= 1'b0;
        end else begin
            valid_q        <= beat;
            last_q         <= beat && tim.symbol_last;
            first_q        <= beat && tim.sample_cnt == '0;
            m_valid_o      <= valid_q;
            m_last_o       <= last_q;
            symbol_start_o <= first_q;
        end
    end

endmodule

//--- logic/frame_sync.sv
`timescale 1ns/1ps

module frame_sync import frame_sync_pkg::*; #(
    parameter int IN_DW    = 32,
    parameter int NFFT     = 8,
    parameter int CLK_FREQ = 3840000
) (
    input  logic               clk_i,
    input  logic               reset_ni,

    input  logic [IN_DW-1:0]   s_axis_in_tdata_i,
    input  logic               s_axis_in_tvalid_i,

    input  logic               n_id_2_valid_i,
    input  logic               ibar_ssb_valid_i,

    output logic [IN_DW-1:0]   m_axis_out_tdata_o,
    output logic [TUSER_W-1:0] m_axis_out_tuser_o,
    output logic               m_axis_out_tvalid_o,
    output logic               m_axis_out_tlast_o,

    output logic               symbol_start_o,
    output logic               ssb_start_o,

    output pss_mode_t          pss_detector_mode_o,
    output sync_state_t        state_o,
    output logic signed [7:0]  sample_cnt_mismatch_o,
    output logic [15:0]        missed_ssbs_o
);

    logic acquire;
    logic realign;
    logic counting;

    // grid position of the beat on the input
    symbol_timing_if #(.NFFT(NFFT)) tim ();

    symbol_counter #(.NFFT(NFFT)) u_symbol_counter (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .s_valid_i  (s_axis_in_tvalid_i),
        .acquire_i  (acquire),
        .realign_i  (realign),
        .counting_i (counting),
        .tim        (tim.counter)
    );

    ssb_tracker #(.NFFT(NFFT)) u_ssb_tracker (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .pss_valid_i           (n_id_2_valid_i),
        .ibar_valid_i          (ibar_ssb_valid_i),
        .tim                   (tim.observer),
        .acquire_o             (acquire),
        .realign_o             (realign),
        .counting_o            (counting),
        .state_o               (state_o),
        .ssb_start_o           (ssb_start_o),
        .sample_cnt_mismatch_o (sample_cnt_mismatch_o)
    );

    pss_mode_ctrl #(.CLK_FREQ(CLK_FREQ)) u_pss_mode_ctrl (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .pss_valid_i   (n_id_2_valid_i),
        .pss_mode_o    (pss_detector_mode_o),
        .missed_ssbs_o (missed_ssbs_o)
    );

    sample_tagger #(.IN_DW(IN_DW)) u_sample_tagger (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_data_i       (s_axis_in_tdata_i),
        .counting_i     (counting),
        .tim            (tim.observer),
        .m_data_o       (m_axis_out_tdata_o),
        .m_tuser_o      (m_axis_out_tuser_o),
        .m_valid_o      (m_axis_out_tvalid_o),
        .m_last_o       (m_axis_out_tlast_o),
        .symbol_start_o (symbol_start_o)
    );

endmodule

//--- testbench/frame_sync_chk.sv
`timescale 1ns/1ps

module frame_sync_chk import frame_sync_pkg::*; (
    input logic        clk_i,
    input logic        reset_ni,
    input logic        tvalid_i,
    input logic        tlast_i,
    input logic        ssb_start_i,
    input sync_state_t state_i
);

    // number of failed assertions so far
    int fail_cnt = 0;

    tlast_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        tlast_i |-> tvalid_i)
        else begin
            $error("tlast is high without tvalid");
            fail_cnt++;
        end

    // SSB start marks a single detection beat
    ssb_start_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ssb_start_i |=> !ssb_start_i)
        else begin
            $error("ssb_start held for more than one cycle");
            fail_cnt++;
        end

    state_encoding_used: assert property (@(posedge clk_i) disable iff (!reset_ni)
        state_i != 2'd3)
        else begin
            $error("sync state holds the unused encoding");
            fail_cnt++;
        end

endmodule

bind frame_sync frame_sync_chk u_chk (
    .clk_i       (clk_i),
    .reset_ni    (reset_ni),
    .tvalid_i    (m_axis_out_tvalid_o),
    .tlast_i     (m_axis_out_tlast_o),
    .ssb_start_i (ssb_start_o),
    .state_i     (state_o)
);

//--- testbench/frame_sync_tb.sv
`timescale 1ns/1ps

module frame_sync_tb import frame_sync_pkg::*; ();

    localparam int IN_DW      = 32;
    localparam int NFFT       = 6;
    localparam int CLK_FREQ   = 50000;
    localparam int FFT_LEN    = 2 ** NFFT;
    localparam int CP1_LEN    = 20 * FFT_LEN / 256;
    localparam int CP2_LEN    = 18 * FFT_LEN / 256;
    localparam int ROWS       = 6;
    localparam int WAIT_LIMIT = 25000;

    // expected output of one input beat
    typedef struct packed {
        logic               valid;
        logic               last;
        logic               start;
        logic [TUSER_W-1:0] tag;
        logic [IN_DW-1:0]   data;
    } beat_t;

    logic               clk_i;
    logic               reset_ni;
    logic [IN_DW-1:0]   s_axis_in_tdata_i;
    logic               s_axis_in_tvalid_i;
    logic               n_id_2_valid_i;
    logic               ibar_ssb_valid_i;
    logic [IN_DW-1:0]   m_axis_out_tdata_o;
    logic [TUSER_W-1:0] m_axis_out_tuser_o;
    logic               m_axis_out_tvalid_o;
    logic               m_axis_out_tlast_o;
    logic               symbol_start_o;
    logic               ssb_start_o;
    pss_mode_t          pss_detector_mode_o;
    sync_state_t        state_o;
    logic signed [7:0]  sample_cnt_mismatch_o;
    logic [15:0]        missed_ssbs_o;

    // detection beat relative to the first beat after the expected end of symbol 279,
    // expected mismatch and state; the last row sends no detection
    int          row_offset   [ROWS] = '{0, 1, 2, -1, -3, 0};
    int          row_mismatch [ROWS] = '{0, 1, 2, 0, -3, 0};
    bit          row_detect   [ROWS] = '{1, 1, 1, 1, 1, 0};
    sync_state_t row_state    [ROWS] = '{SYNCED, SYNCED, SYNCED, SYNCED, SYNCED, WAIT_FOR_SSB};

    // grid model of the beat being driven
    int          m_cnt = 0;
    int          m_sym = 0;
    int          m_sf = 0;
    int          m_sfn = 0;
    int          m_cp = CP2_LEN;
    int          m_syms = 0;
    bit          m_counting = 0;
    bit          ssb_due = 0;
    logic [31:0] lfsr = 32'd39;
    beat_t       pipe [3] = '{default: '0};

    frame_sync #(.IN_DW(IN_DW), .NFFT(NFFT), .CLK_FREQ(CLK_FREQ)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic next_sample(output logic [IN_DW-1:0] sample);
        sample = '0;
        for (int b = 0; b < IN_DW; b++) begin
            lfsr   = lfsr_step(lfsr);
            sample = {sample[IN_DW-2:0], lfsr[0]};
        end
    endtask

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic advance_grid(input logic last, input logic detect);
        if (last) begin
            if (m_sym == SYM_PER_SF - 1) begin
                if (m_sf == SUBFRAMES_PER_FRAME - 1) begin
                    m_sf  = 0;
                    m_sfn = (m_sfn + 1) % SFN_COUNT;
                end else begin
                    m_sf = m_sf + 1;
                end
            end
            m_sym  = (m_sym + 1) % SYM_PER_SF;
            // long CP opens each half subframe
            m_cp   = (m_sym == 0 || m_sym == 7) ? CP1_LEN : CP2_LEN;
            m_syms = (detect || m_syms == SYMS_BTWN_SSB - 1) ? 0 : m_syms + 1;
            m_cnt  = 0;
        end else begin
            m_cnt = m_cnt + 1;
        end
    endtask

    // drive one beat, then check the output of the beat driven two cycles earlier
    task automatic run_beat(input logic pss, input logic ibar, input logic detect);
        logic [IN_DW-1:0] sample;
        beat_t            cur;
        @(posedge clk_i);
        next_sample(sample);
        s_axis_in_tdata_i <= sample;
        n_id_2_valid_i    <= pss;
        ibar_ssb_valid_i  <= ibar;
        cur       = '0;
        cur.valid = m_counting;
        cur.data  = sample;
        if (m_counting) begin
            cur.tag   = {SFN_W'(m_sfn), SUBFRAME_W'(m_sf), SYM_W'(m_sym), CP_LEN_W'(m_cp)};
            cur.start = m_cnt == 0;
            cur.last  = m_cnt == FFT_LEN + m_cp - 1 || detect;
            advance_grid(cur.last, detect);
        end
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        pipe[0] = cur;
        @(negedge clk_i);
        compare("m_axis_out_tvalid_o", m_axis_out_tvalid_o, pipe[2].valid);
        compare("m_axis_out_tlast_o", m_axis_out_tlast_o, pipe[2].last);
        compare("symbol_start_o", symbol_start_o, pipe[2].start);
        if (pipe[2].valid) begin
            compare("m_axis_out_tuser_o", m_axis_out_tuser_o, pipe[2].tag);
            compare("m_axis_out_tdata_o", m_axis_out_tdata_o, pipe[2].data);
        end
        compare("ssb_start_o", ssb_start_o, ssb_due);
        compare("assertion failures", dut0.u_chk.fail_cnt, 0);
        ssb_due = detect;
    endtask

    initial begin
        int wait_cnt;
        int k_det;
        reset_ni           = 1'b0;
        s_axis_in_tdata_i  = '0;
        s_axis_in_tvalid_i = 1'b1;
        n_id_2_valid_i     = 1'b0;
        ibar_ssb_valid_i   = 1'b0;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        compare("m_axis_out_tvalid_o", m_axis_out_tvalid_o, 0);
        compare("m_axis_out_tlast_o", m_axis_out_tlast_o, 0);
        compare("symbol_start_o", symbol_start_o, 0);
        compare("ssb_start_o", ssb_start_o, 0);
        compare("state_o", state_o, WAIT_FOR_SSB);
        compare("pss_detector_mode_o", pss_detector_mode_o, MODE_SEARCH);
        compare("sample_cnt_mismatch_o", sample_cnt_mismatch_o, 0);
        compare("missed_ssbs_o", missed_ssbs_o, 0);
        repeat (20) run_beat(1'b0, 1'b0, 1'b0);

        // first detection starts the grid at symbol 2 with the short CP
        run_beat(1'b1, 1'b0, 1'b0);
        m_sym      = 2;
        m_cp       = CP2_LEN;
        m_counting = 1;
        for (int i = 1; i <= 1020; i++) begin
            run_beat(1'b0, i == 10, 1'b0);
            if (i == 1) compare("state_o", state_o, WAIT_FOR_IBAR);
            if (i == 11) compare("state_o", state_o, SYNCED);
            if (i == 500) compare("pss_detector_mode_o", pss_detector_mode_o, MODE_PAUSE);
            if (i == 1000) compare("pss_detector_mode_o", pss_detector_mode_o, MODE_FIND);
            if (i == 1020) begin
                compare("pss_detector_mode_o", pss_detector_mode_o, MODE_SEARCH);
                compare("missed_ssbs_o", missed_ssbs_o, 1);
            end
        end

        for (int r = 0; r < ROWS; r++) begin
            wait_cnt = 0;
            while (!(m_syms == SYMS_BTWN_SSB - 1
                     && m_cnt == FFT_LEN + m_cp - FIND_EARLY_SAMPLES)) begin
                run_beat(1'b0, 1'b0, 1'b0);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    $display("Timeout: the find window of row %0d never came up", r);
                    abort_run();
                end
            end
            // beat 0 opens the window, beat 4 is the first one of the next symbol
            if (row_detect[r]) begin
                k_det = FIND_EARLY_SAMPLES + row_offset[r];
                for (int k = 0; k <= k_det; k++) begin
                    run_beat(k == k_det, 1'b0, k == k_det);
                end
                run_beat(1'b0, 1'b0, 1'b0);
                compare("sample_cnt_mismatch_o", sample_cnt_mismatch_o, row_mismatch[r]);
            end else begin
                for (int k = 0; k <= FIND_EARLY_SAMPLES + FIND_LATE_SAMPLES; k++) begin
                    run_beat(1'b0, 1'b0, 1'b0);
                end
                m_counting = 0;
                run_beat(1'b0, 1'b0, 1'b0);
            end
            compare("state_o", state_o, row_state[r]);
        end

        // output drains and then stays idle
        repeat (8) run_beat(1'b0, 1'b0, 1'b0);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- compile.f
logic/frame_sync_pkg.sv
logic/symbol_timing_if.sv
logic/symbol_counter.sv
logic/ssb_tracker.sv
logic/pss_mode_ctrl.sv
logic/sample_tagger.sv
logic/frame_sync.sv
testbench/frame_sync_chk.sv
testbench/frame_sync_tb.sv
